//--- muldiv_cfg_pkg.sv
`default_nettype none

package muldiv_cfg_pkg;

    // Number of SIMD lanes served by one request
    localparam int num_lanes = 2;

    // Data width of one lane
    localparam int xlen = 32;

    // Instruction tag fields carried alongside each operation
    localparam int uuid_w  = 8;
    localparam int wid_w   = 2;
    localparam int nr_bits = 5;

    // Registered stages in the multiplier, at least two
    localparam int mul_latency = 3;

    // One quotient bit is produced per iteration
    localparam int div_cycles = 32;

    // Width of the divider iteration counter
    localparam int div_cnt_w = $clog2(div_cycles);

endpackage

`default_nettype wire

//--- muldiv_types_pkg.sv
`default_nettype none

package muldiv_types_pkg;
    import muldiv_cfg_pkg::*;

    // Same layout as the RISC-V M funct3 field, bit 2 selects the divider
    typedef enum logic [2:0] {
        op_mul    = 3'd0,
        op_mulh   = 3'd1,
        op_mulhsu = 3'd2,
        op_mulhu  = 3'd3,
        op_div    = 3'd4,
        op_divu   = 3'd5,
        op_rem    = 3'd6,
        op_remu   = 3'd7
    } muldiv_op_e;

    typedef logic [num_lanes-1:0][xlen-1:0] lane_data_t;

    // Everything that has to come back with the result
    typedef struct packed {
        logic [uuid_w-1:0]    uuid;
        logic [wid_w-1:0]     wid;
        logic [num_lanes-1:0] tmask;
        logic [nr_bits-1:0]   rd;
    } muldiv_tag_t;

    typedef struct packed {
        muldiv_tag_t tag;
        muldiv_op_e  op;
        lane_data_t  rs1;
        lane_data_t  rs2;
    } muldiv_req_t;

    typedef struct packed {
        muldiv_tag_t tag;
        lane_data_t  data;
    } muldiv_rsp_t;

endpackage

`default_nettype wire

//--- stream_if.sv
`timescale 1ns/100ps
`default_nettype none

// Valid/ready stream, a beat moves when both are high on a clock edge
interface stream_if #(
    parameter type payload_t = logic
);
    logic     valid;
    logic     ready;
    payload_t data;

    modport source (
        output valid,
        output data,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        output ready
    );
endinterface

`default_nettype wire

//--- mul_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module mul_pipe (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  muldiv_types_pkg::muldiv_tag_t tag,
    input  muldiv_types_pkg::muldiv_op_e  op,
    input  muldiv_types_pkg::lane_data_t  rs1,
    input  muldiv_types_pkg::lane_data_t  rs2,
    stream_if.source                      out
);
    import muldiv_cfg_pkg::*;
    import muldiv_types_pkg::*;

    logic                   adv;
    logic                   sign_a;
    logic                   sign_b;
    logic [xlen:0]          a_ext [num_lanes];
    logic [xlen:0]          b_ext [num_lanes];
    logic [xlen:0]          a_q [num_lanes];
    logic [xlen:0]          b_q [num_lanes];
    logic [2*xlen+1:0]      prod_c [num_lanes];
    logic [2*xlen+1:0]      prod_q [mul_latency-1][num_lanes];
    logic [mul_latency-1:0] vld_q;
    logic [mul_latency-1:0] hi_q;
    muldiv_tag_t            tag_q [mul_latency];
    muldiv_rsp_t            rsp;

    // MULHSU takes rs1 as signed and rs2 as unsigned
    assign sign_a = (op == op_mulh) || (op == op_mulhsu);
    assign sign_b = (op == op_mulh);

    // A 33 bit signed product covers every signedness combination
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            a_ext[i]  = {sign_a & rs1[i][xlen-1], rs1[i]};
            b_ext[i]  = {sign_b & rs2[i][xlen-1], rs2[i]};
            prod_c[i] = $signed(a_q[i]) * $signed(b_q[i]);
        end
    end

    // The whole pipe moves together whenever the last stage can empty
    assign adv      = ~vld_q[mul_latency-1] | out.ready;
    assign in_ready = adv;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else if (adv) begin
            vld_q <= {vld_q[mul_latency-2:0], in_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            hi_q     <= {hi_q[mul_latency-2:0], op != op_mul};
            tag_q[0] <= tag;
            for (int s = 1; s < mul_latency; s++) begin
                tag_q[s] <= tag_q[s-1];
            end
            for (int i = 0; i < num_lanes; i++) begin
                a_q[i]       <= a_ext[i];
                b_q[i]       <= b_ext[i];
                prod_q[0][i] <= prod_c[i];
                for (int s = 1; s < mul_latency - 1; s++) begin
                    prod_q[s][i] <= prod_q[s-1][i];
                end
            end
        end
    end

    always_comb begin
        rsp.tag = tag_q[mul_latency-1];
        for (int i = 0; i < num_lanes; i++) begin
            rsp.data[i] = hi_q[mul_latency-1] ? prod_q[mul_latency-2][i][2*xlen-1:xlen]
                                              : prod_q[mul_latency-2][i][xlen-1:0];
        end
    end

    assign out.valid = vld_q[mul_latency-1];
    assign out.data  = rsp;

endmodule

`default_nettype wire

//--- serial_div.sv
`timescale 1ns/100ps
`default_nettype none

module serial_div (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  muldiv_types_pkg::muldiv_tag_t tag,
    input  muldiv_types_pkg::muldiv_op_e  op,
    input  muldiv_types_pkg::lane_data_t  rs1,
    input  muldiv_types_pkg::lane_data_t  rs2,
    stream_if.source                      out
);
    import muldiv_cfg_pkg::*;
    import muldiv_types_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_busy,
        s_done
    } state_e;

    state_e               state;
    logic [div_cnt_w-1:0] cnt;
    logic                 last_step;
    logic [num_lanes-1:0] sa_c;
    logic [num_lanes-1:0] sb_c;
    logic [num_lanes-1:0] q_neg;
    logic [num_lanes-1:0] r_neg;
    logic [num_lanes-1:0] d_zero;
    logic                 rem_sel;
    muldiv_tag_t          tag_q;
    lane_data_t           quo_q;
    lane_data_t           rem_q;
    lane_data_t           den_q;
    lane_data_t           quo_n;
    lane_data_t           rem_n;
    lane_data_t           res_c;
    lane_data_t           res_q;

    // Signed ops are DIV and REM, which have funct3 bit 0 clear
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            sa_c[i] = ~op[0] & rs1[i][xlen-1];
            sb_c[i] = ~op[0] & rs2[i][xlen-1];
        end
    end

    assign last_step = (cnt == div_cnt_w'(div_cycles - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= s_idle;
            cnt   <= '0;
        end else begin
            case (state)
                s_idle: if (in_valid) begin
                    state <= s_busy;
                    cnt   <= '0;
                end
                s_busy: begin
                    cnt <= cnt + 1'b1;
                    if (last_step) state <= s_done;
                end
                default: if (out.ready) state <= s_idle;
            endcase
        end
    end

    // One restoring step per lane, quotient bits shift in from the right
    // A zero divisor naturally gives all ones and the dividend magnitude
    always_comb begin
        logic [xlen+1:0] diff;
        for (int i = 0; i < num_lanes; i++) begin
            diff = {1'b0, rem_q[i], quo_q[i][xlen-1]} - {2'b00, den_q[i]};
            if (diff[xlen+1]) begin
                rem_n[i] = {rem_q[i][xlen-2:0], quo_q[i][xlen-1]};
                quo_n[i] = {quo_q[i][xlen-2:0], 1'b0};
            end else begin
                rem_n[i] = diff[xlen-1:0];
                quo_n[i] = {quo_q[i][xlen-2:0], 1'b1};
            end
            // Most negative over minus one already yields 8000_0000 and zero here
            if (rem_sel) begin
                res_c[i] = r_neg[i] ? -rem_n[i] : rem_n[i];
            end else if (d_zero[i]) begin
                res_c[i] = '1;
            end else begin
                res_c[i] = q_neg[i] ? -quo_n[i] : quo_n[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == s_idle && in_valid) begin
            tag_q   <= tag;
            rem_sel <= op[1];
            for (int i = 0; i < num_lanes; i++) begin
                quo_q[i]  <= sa_c[i] ? -rs1[i] : rs1[i];
                den_q[i]  <= sb_c[i] ? -rs2[i] : rs2[i];
                rem_q[i]  <= '0;
                q_neg[i]  <= sa_c[i] ^ sb_c[i];
                r_neg[i]  <= sa_c[i];
                d_zero[i] <= (rs2[i] == '0);
            end
        end else if (state == s_busy) begin
            quo_q <= quo_n;
            rem_q <= rem_n;
            if (last_step) res_q <= res_c;
        end
    end

    assign in_ready      = (state == s_idle);
    assign out.valid     = (state == s_done);
    assign out.data.tag  = tag_q;
    assign out.data.data = res_q;

endmodule

`default_nettype wire

//--- rsp_arb.sv
`timescale 1ns/100ps
`default_nettype none

module rsp_arb #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    stream_if.sink   in0,
    stream_if.sink   in1,
    stream_if.source out
);
    logic     load;
    logic     grant0;
    logic     grant1;
    logic     prio;
    logic     valid_q;
    payload_t data_q;

    // The output register refills when empty or while it is being drained
    assign load = ~valid_q | out.ready;

    // When prio is set, input 1 wins a tie
    assign grant1 = in1.valid & (~in0.valid | prio);
    assign grant0 = in0.valid & ~grant1;

    assign in0.ready = load & grant0;
    assign in1.ready = load & grant1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            prio    <= 1'b0;
        end else if (load) begin
            valid_q <= in0.valid | in1.valid;
            // Whoever was served gives way next time
            if (in0.valid | in1.valid) prio <= grant0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= grant1 ? in1.data : in0.data;
        end
    end

    assign out.valid = valid_q;
    assign out.data  = data_q;

endmodule

`default_nettype wire

//--- muldiv_unit.sv
`timescale 1ns/100ps
`default_nettype none

module muldiv_unit (
    input  logic     clk,
    input  logic     rst_n,
    stream_if.sink   execute_if,
    stream_if.source commit_if
);
    import muldiv_types_pkg::*;

    logic is_div;
    logic mul_in_valid;
    logic mul_in_ready;
    logic div_in_valid;
    logic div_in_ready;

    stream_if #(.payload_t(muldiv_rsp_t)) mul_rsp_if ();
    stream_if #(.payload_t(muldiv_rsp_t)) div_rsp_if ();

    // Divide and remainder ops all have bit 2 of the op set
    assign is_div = execute_if.data.op[2];

    assign mul_in_valid = execute_if.valid & ~is_div;
    assign div_in_valid = execute_if.valid & is_div;

    // Ready follows the engine the current request is headed for
    assign execute_if.ready = is_div ? div_in_ready : mul_in_ready;

    mul_pipe u_mul_pipe (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (mul_in_valid),
        .in_ready (mul_in_ready),
        .tag      (execute_if.data.tag),
        .op       (execute_if.data.op),
        .rs1      (execute_if.data.rs1),
        .rs2      (execute_if.data.rs2),
        .out      (mul_rsp_if.source)
    );

    serial_div u_serial_div (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (div_in_valid),
        .in_ready (div_in_ready),
        .tag      (execute_if.data.tag),
        .op       (execute_if.data.op),
        .rs1      (execute_if.data.rs1),
        .rs2      (execute_if.data.rs2),
        .out      (div_rsp_if.source)
    );

    // Results may commit out of request order, the tag identifies each one
    rsp_arb #(
        .payload_t (muldiv_rsp_t)
    ) u_rsp_arb (
        .clk   (clk),
        .rst_n (rst_n),
        .in0   (mul_rsp_if.sink),
        .in1   (div_rsp_if.sink),
        .out   (commit_if)
    );

endmodule

`default_nettype wire

//--- muldiv_top.sv
`timescale 1ns/100ps
`default_nettype none

module muldiv_top (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        req_valid,
    output logic                                        req_ready,
    input  logic [muldiv_cfg_pkg::uuid_w-1:0]           req_uuid,
    input  logic [muldiv_cfg_pkg::wid_w-1:0]            req_wid,
    input  logic [muldiv_cfg_pkg::num_lanes-1:0]        req_tmask,
    input  logic [muldiv_cfg_pkg::nr_bits-1:0]          req_rd,
    input  logic [2:0]                                  req_op,
    input  logic [muldiv_cfg_pkg::num_lanes-1:0]
                 [muldiv_cfg_pkg::xlen-1:0]             req_rs1,
    input  logic [muldiv_cfg_pkg::num_lanes-1:0]
                 [muldiv_cfg_pkg::xlen-1:0]             req_rs2,
    output logic                                        rsp_valid,
    input  logic                                        rsp_ready,
    output logic [muldiv_cfg_pkg::uuid_w-1:0]           rsp_uuid,
    output logic [muldiv_cfg_pkg::wid_w-1:0]            rsp_wid,
    output logic [muldiv_cfg_pkg::num_lanes-1:0]        rsp_tmask,
    output logic [muldiv_cfg_pkg::nr_bits-1:0]          rsp_rd,
    output logic [muldiv_cfg_pkg::num_lanes-1:0]
                 [muldiv_cfg_pkg::xlen-1:0]             rsp_data
);
    import muldiv_types_pkg::*;

    stream_if #(.payload_t(muldiv_req_t)) execute_if ();
    stream_if #(.payload_t(muldiv_rsp_t)) commit_if ();

    assign execute_if.valid = req_valid;
    assign req_ready        = execute_if.ready;
    assign execute_if.data  = '{
        tag: '{uuid: req_uuid, wid: req_wid, tmask: req_tmask, rd: req_rd},
        op:  muldiv_op_e'(req_op),
        rs1: req_rs1,
        rs2: req_rs2
    };

    assign rsp_valid       = commit_if.valid;
    assign commit_if.ready = rsp_ready;
    assign rsp_uuid        = commit_if.data.tag.uuid;
    assign rsp_wid         = commit_if.data.tag.wid;
    assign rsp_tmask       = commit_if.data.tag.tmask;
    assign rsp_rd          = commit_if.data.tag.rd;
    assign rsp_data        = commit_if.data.data;

    muldiv_unit u_muldiv_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .execute_if (execute_if.sink),
        .commit_if  (commit_if.source)
    );

endmodule

`default_nettype wire

//--- tb_muldiv.sv
`timescale 1ns/100ps
`default_nettype none

module tb_muldiv;
    import muldiv_cfg_pkg::*;

    localparam int max_vec  = 64;
    localparam int vec_cols = 8;

    logic                           clk;
    logic                           rst_n;
    logic                           req_valid;
    logic                           req_ready;
    logic [uuid_w-1:0]              req_uuid;
    logic [wid_w-1:0]               req_wid;
    logic [num_lanes-1:0]           req_tmask;
    logic [nr_bits-1:0]             req_rd;
    logic [2:0]                     req_op;
    logic [num_lanes-1:0][xlen-1:0] req_rs1;
    logic [num_lanes-1:0][xlen-1:0] req_rs2;
    logic                           rsp_valid;
    logic                           rsp_ready;
    logic [uuid_w-1:0]              rsp_uuid;
    logic [wid_w-1:0]               rsp_wid;
    logic [num_lanes-1:0]           rsp_tmask;
    logic [nr_bits-1:0]             rsp_rd;
    logic [num_lanes-1:0][xlen-1:0] rsp_data;

    // Each vector holds op, tmask, rs1 and rs2 for both lanes and the two expected words
    logic [31:0] vec_mem [vec_cols*max_vec];
    int          num_vec = 0;
    bit          vectors_loaded = 1'b0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_bad = 0;
    int          recv_count = 0;
    int          seen [max_vec];
    int          cycle_cnt = 0;
    bit          random_bp = 1'b0;
    logic        bp_next;

    muldiv_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_uuid  (req_uuid),
        .req_wid   (req_wid),
        .req_tmask (req_tmask),
        .req_rd    (req_rd),
        .req_op    (req_op),
        .req_rs1   (req_rs1),
        .req_rs2   (req_rs2),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_uuid  (rsp_uuid),
        .rsp_wid   (rsp_wid),
        .rsp_tmask (rsp_tmask),
        .rsp_rd    (rsp_rd),
        .rsp_data  (rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // Destination register and warp id are made up from the uuid
    function automatic logic [nr_bits-1:0] exp_rd(input int idx);
        return nr_bits'(idx * 3 + 1);
    endfunction

    function automatic logic [wid_w-1:0] exp_wid(input int idx);
        return wid_w'(idx);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, got);
        errors++;
    endtask

    task automatic load_vectors();
        for (int i = 0; i < vec_cols * max_vec; i++) begin
            vec_mem[i] = 32'hffff_0000 | 32'(i);
        end
        $readmemh("muldiv_vectors.txt", vec_mem);
        while (num_vec < max_vec && vec_mem[vec_cols*num_vec] < 32'd8) begin
            num_vec++;
        end
        vectors_loaded = 1'b1;
    endtask

    task automatic check_response();
        int idx;
        int base;
        idx = int'(rsp_uuid);
        base = vec_cols * idx;
        recv_count++;
        if (idx >= num_vec) begin
            $display("At %0t a response came back with unknown uuid %0d", $time, idx);
            errors++;
        end else if (seen[idx] != 0) begin
            $display("At %0t uuid %0d came back a second time", $time, idx);
            seen[idx]++;
            errors++;
        end else begin
            seen[idx] = 1;
            if (rsp_tmask !== vec_mem[base+1][num_lanes-1:0])
                report_mismatch("rsp_tmask", vec_mem[base+1], 32'(rsp_tmask));
            if (rsp_rd !== exp_rd(idx))
                report_mismatch("rsp_rd", 32'(exp_rd(idx)), 32'(rsp_rd));
            if (rsp_wid !== exp_wid(idx))
                report_mismatch("rsp_wid", 32'(exp_wid(idx)), 32'(rsp_wid));
            for (int l = 0; l < num_lanes; l++) begin
                if (vec_mem[base+1][l] && rsp_data[l] !== vec_mem[base+6+l])
                    report_mismatch($sformatf("rsp_data[%0d]", l), vec_mem[base+6+l],
                                    rsp_data[l]);
            end
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && rsp_valid && rsp_ready) check_response();
    end

    // Draw at the falling edge and drive after the rising edge
    initial begin
        forever begin
            @(negedge clk);
            bp_next = random_bp ? 1'($urandom % 2) : 1'b1;
            @(posedge clk);
            #2;
            rsp_ready = bp_next;
        end
    end

    task automatic send_vector(input int idx, input bit check_ready, input bit ready_exp,
                               output int acc_cycle);
        int base;
        bit first;
        bit accepted;
        base = vec_cols * idx;
        req_uuid  = uuid_w'(idx);
        req_wid   = exp_wid(idx);
        req_rd    = exp_rd(idx);
        req_op    = vec_mem[base][2:0];
        req_tmask = vec_mem[base+1][num_lanes-1:0];
        req_rs1   = {vec_mem[base+3], vec_mem[base+2]};
        req_rs2   = {vec_mem[base+5], vec_mem[base+4]};
        req_valid = 1'b1;
        first     = 1'b1;
        accepted  = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            if (check_ready && first && req_ready !== ready_exp)
                report_mismatch("req_ready", 32'(ready_exp), 32'(req_ready));
            first    = 1'b0;
            accepted = req_ready;
            if (!accepted) begin
                @(posedge clk);
                #2;
            end
        end
        acc_cycle = cycle_cnt;
        @(posedge clk);
        #2;
        req_valid = 1'b0;
    endtask

    // Edges from the accepting edge up to the one that raises rsp_valid
    task automatic check_latency(input int acc, input int expected);
        do begin
            @(negedge clk);
        end while (rsp_valid !== 1'b1);
        if (cycle_cnt - acc != expected)
            report_mismatch("rsp_valid latency", expected, cycle_cnt - acc);
        @(posedge clk);
        #2;
    endtask

    task automatic wait_drain(input int count);
        while (recv_count < count) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic set_backpressure(input bit on);
        random_bp = on;
        @(posedge clk);
        #2;
    endtask

    task automatic end_test(input string name, input int err_mark);
        tests_run++;
        if (errors != err_mark) tests_bad++;
        $display("[%s] finished with %0d errors", name, errors - err_mark);
    endtask

    // Vector 0 is a multiply, vector 1 a divide, and the last four are div, mul, mul, div
    task automatic run_tests();
        int acc;
        int err_mark;
        int last_rand;
        err_mark = errors;
        @(negedge clk);
        if (rsp_valid !== 1'b0) report_mismatch("rsp_valid", 0, 32'(rsp_valid));
        if (req_ready !== 1'b1) report_mismatch("req_ready", 1, 32'(req_ready));
        @(posedge clk);
        #2;
        end_test("reset", err_mark);

        err_mark = errors;
        send_vector(0, 1'b1, 1'b1, acc);
        check_latency(acc, mul_latency + 1);
        wait_drain(1);
        send_vector(1, 1'b1, 1'b1, acc);
        check_latency(acc, div_cycles + 2);
        wait_drain(2);
        end_test("latency", err_mark);

        err_mark = errors;
        last_rand = num_vec - 4;
        set_backpressure(1'b1);
        for (int i = 2; i < last_rand; i++) begin
            repeat ($urandom % 4) begin
                @(posedge clk);
                #2;
            end
            send_vector(i, 1'b0, 1'b1, acc);
        end
        set_backpressure(1'b0);
        wait_drain(last_rand);
        end_test("random", err_mark);

        err_mark = errors;
        send_vector(last_rand, 1'b1, 1'b1, acc);
        send_vector(last_rand + 1, 1'b1, 1'b1, acc);
        send_vector(last_rand + 2, 1'b1, 1'b1, acc);
        send_vector(last_rand + 3, 1'b1, 1'b0, acc);
        wait_drain(num_vec);
        end_test("back_to_back", err_mark);

        // Let any stray duplicate show up before counting
        err_mark = errors;
        repeat (div_cycles + 4) @(posedge clk);
        if (recv_count != num_vec) begin
            $display("Got %0d responses for %0d requests", recv_count, num_vec);
            errors++;
        end
        for (int i = 0; i < num_vec; i++) begin
            if (seen[i] != 1) begin
                $display("uuid %0d came back %0d times", i, seen[i]);
                errors++;
            end
        end
        end_test("completeness", err_mark);
    endtask

    initial begin
        void'($urandom(32'h20f9_1826));
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_uuid  = '0;
        req_wid   = '0;
        req_tmask = '0;
        req_rd    = '0;
        req_op    = '0;
        req_rs1   = '0;
        req_rs2   = '0;
        rsp_ready = 1'b1;
        for (int i = 0; i < max_vec; i++) seen[i] = 0;
        load_vectors();
        if (num_vec < 6) begin
            $display("Too few vectors read from muldiv_vectors.txt: %0d", num_vec);
            errors++;
        end else begin
            repeat (5) @(posedge clk);
            #2;
            rst_n = 1'b1;
            run_tests();
        end
        $display("%0d tests run, %0d with errors, %0d errors in total, %0d of %0d responses",
                 tests_run, tests_bad, errors, recv_count, num_vec);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        wait (vectors_loaded);
        #((num_vec > 0 ? num_vec : 1) * (div_cycles + 10) * 20 * 4);
        $display("Timeout: the run did not finish in the time allowed for %0d vectors", num_vec);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- muldiv_vectors.txt
// op tmask rs1_lane0 rs1_lane1 rs2_lane0 rs2_lane1 exp_lane0 exp_lane1 (hex)
// op follows funct3: 0 mul, 1 mulh, 2 mulhsu, 3 mulhu, 4 div, 5 divu, 6 rem, 7 remu
0 3 00000007 00000010 00000006 fffffffd 0000002a ffffffd0
4 3 00000064 ffffff9c 00000007 00000007 0000000e fffffff2
1 3 80000000 7fffffff 80000000 7fffffff 40000000 3fffffff
3 3 ffffffff 80000000 ffffffff 00000002 fffffffe 00000001
2 3 ffffffff 00000002 ffffffff 80000000 ffffffff 00000001
0 3 fffffffe 12345678 fffffffd 00000010 00000006 23456780
5 3 ffffffff 00000064 00000002 00000007 7fffffff 0000000e
6 3 ffffff9c 00000064 00000007 fffffff9 fffffffe 00000002
7 3 ffffffff 00000064 00000010 00000007 0000000f 00000002
4 3 00000005 fffffffb 00000000 00000000 ffffffff ffffffff
6 3 00000005 fffffffb 00000000 00000000 00000005 fffffffb
5 3 12345678 00000000 00000000 00000000 ffffffff ffffffff
7 3 12345678 00000000 00000000 00000000 12345678 00000000
4 3 80000000 80000000 ffffffff 00000001 80000000 80000000
6 3 80000000 80000000 ffffffff 00000003 00000000 fffffffe
0 1 00000003 deadbeef 00000005 00000002 0000000f 00000000
4 2 00000010 fffffff0 00000003 00000005 00000000 fffffffd
2 3 80000000 00000003 00000002 ffffffff ffffffff 00000002
0 3 ffffffff 00010000 ffffffff 00010000 00000001 00000000
4 3 fffffff9 7fffffff fffffffe ffffffff 00000003 80000001

//--- verilog.f
muldiv_cfg_pkg.sv
muldiv_types_pkg.sv
stream_if.sv
mul_pipe.sv
serial_div.sv
rsp_arb.sv
muldiv_unit.sv
muldiv_top.sv
tb_muldiv.sv

//--- Makefile
SRCS := $(shell cat verilog.f)

obj_dir/Vtb_muldiv: verilog.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_muldiv -f verilog.f

run: obj_dir/Vtb_muldiv muldiv_vectors.txt
	./obj_dir/Vtb_muldiv | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
